/* hdl/pong_pkg.sv */
`default_nettype none
//////////////////////////////////////////////////////////////////////
// playfield geometry, timing constants and shared types of the game
// coordinates are whole pixels of a 1280x720 active area
//////////////////////////////////////////////////////////////////////

package pong_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////
  localparam int coord_bits   = 12;
  localparam int active_pels  = 1280;
  localparam int active_lines = 720;
  localparam int ball_size    = 16;
  localparam int paddle_size  = 64;

  // ball centre range, extra 8 pixel margin top and bottom
  localparam int ball_min_x = ball_size;
  localparam int ball_max_x = active_pels - ball_size;
  localparam int ball_min_y = ball_size + 8;
  localparam int ball_max_y = active_lines - (ball_size + 8);

  localparam int paddle_min       = paddle_size / 2;                  // centre limits
  localparam int paddle_max       = active_lines - paddle_size / 2;
  localparam int paddle_hit_range = ball_size / 2 + paddle_size / 2;  // |dy| below this

  //////////////////////////////////////////////////////////////////////
  // speed and timeouts
  //////////////////////////////////////////////////////////////////////
  localparam int speed_bits  = 6;
  localparam int start_speed = 4;   // pixels per frame
  localparam int step_speed  = 1;   // added each second of play
  localparam int max_speed   = 24;

  localparam int idle_timeout_sec = 30;
  localparam int wait_timeout_sec = 5;
  localparam int finished_sec     = 3;
  localparam int sec_bits         = 8;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////
  typedef logic [coord_bits-1:0] coord_t;

  typedef enum logic [2:0] {
    mode_idle       = 3'd0,
    mode_demo       = 3'd1,
    mode_wait_left  = 3'd2,  // right pressed, left still missing
    mode_wait_right = 3'd3,  // left pressed, right still missing
    mode_one_left   = 3'd4,
    mode_one_right  = 3'd5,
    mode_two        = 3'd6,
    mode_finished   = 3'd7
  } game_mode_t;

  // top-left corner of one object
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   en;
  } obj_t;

  typedef struct packed {
    logic motion_en;
    logic paddle_l_en;
    logic paddle_r_en;
    logic init_game;    // hold ball and paddles at start position
  } play_ctrl_t;

endpackage

`default_nettype wire

/* hdl/game_fsm.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////////////////////////
// clk_rate is the number of clk cycles in one second
// buttons are levels; only the edge out of idle, demo or wait counts
// bounce is expected as a level lasting one frame
//////////////////////////////////////////////////////////////////////

module game_fsm #(
  parameter int clk_rate = 49500000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 btn_l,
  input  logic                 btn_r,
  input  logic                 game_failed,
  input  logic                 bounce,
  output pong_pkg::play_ctrl_t ctrl,
  output logic                 sec_tick,
  output pong_pkg::game_mode_t mode,
  output logic                 play_sound
);
  import pong_pkg::*;

  localparam int cnt_bits = $clog2(clk_rate + 1);

  logic [cnt_bits-1:0] clk_cnt;
  logic [sec_bits-1:0] sec_cnt;   // seconds spent in a timed mode
  logic                timed_mode;
  logic                in_play;
  logic                bounce_d;

  //////////////////////////////////////////////////////////////////////
  // second timer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      clk_cnt  <= '0;
      sec_tick <= 1'b0;
    end else if (clk_cnt == cnt_bits'(clk_rate - 1)) begin
      clk_cnt  <= '0;
      sec_tick <= 1'b1;
    end else begin
      clk_cnt  <= clk_cnt + cnt_bits'(1);
      sec_tick <= 1'b0;
    end
  end

  always_comb begin
    timed_mode = mode inside {mode_idle, mode_wait_left, mode_wait_right, mode_finished};
    in_play    = mode inside {mode_one_left, mode_one_right, mode_two};
  end

  //////////////////////////////////////////////////////////////////////
  // mode state machine
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      mode    <= mode_idle;
      sec_cnt <= '0;
    end else begin
      if (sec_tick && timed_mode) begin
        sec_cnt <= sec_cnt + sec_bits'(1);
      end
      case (mode)
        mode_idle, mode_demo: begin
          if (btn_r) begin
            mode    <= mode_wait_left;
            sec_cnt <= '0;
          end else if (btn_l) begin
            mode    <= mode_wait_right;
            sec_cnt <= '0;
          end else if (mode == mode_idle && sec_cnt > sec_bits'(idle_timeout_sec)) begin
            mode    <= mode_demo;
          end
        end
        mode_wait_left: begin
          if (btn_l) begin
            mode <= mode_two;
          end else if (sec_cnt > sec_bits'(wait_timeout_sec)) begin
            mode <= mode_one_right;   // nobody joined the right player
          end
        end
        mode_wait_right: begin
          if (btn_r) begin
            mode <= mode_two;
          end else if (sec_cnt > sec_bits'(wait_timeout_sec)) begin
            mode <= mode_one_left;
          end
        end
        mode_one_left, mode_one_right, mode_two: begin
          if (game_failed) begin
            mode    <= mode_finished;
            sec_cnt <= '0;
          end
        end
        mode_finished: begin
          if (sec_cnt > sec_bits'(finished_sec)) begin
            mode    <= mode_idle;
            sec_cnt <= '0;
          end
        end
        default: mode <= mode_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // enables and sound, one clock behind mode
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl       <= '{motion_en: 1'b0, paddle_l_en: 1'b0, paddle_r_en: 1'b0, init_game: 1'b1};
      bounce_d   <= 1'b0;
      play_sound <= 1'b0;
    end else begin
      ctrl.motion_en <= in_play || (mode == mode_demo);
      ctrl.init_game <= mode inside {mode_idle, mode_wait_left, mode_wait_right};
      // paddles stay visible during game over
      if (mode != mode_finished) begin
        ctrl.paddle_l_en <= mode inside {mode_wait_right, mode_one_left, mode_two};
        ctrl.paddle_r_en <= mode inside {mode_wait_left, mode_one_right, mode_two};
      end
      bounce_d   <= bounce;
      play_sound <= in_play && ((bounce && !bounce_d) || game_failed);  // failure = entry tone
    end
  end

endmodule

`default_nettype wire

/* hdl/paddle_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////////////////////////
// paddle centre, moves step pixels per clock while motion is on
// up wins over down
//////////////////////////////////////////////////////////////////////

module paddle_ctrl (
  input  logic             clk,
  input  logic             reset,
  input  logic             init_game,
  input  logic             motion_en,
  input  logic             up,
  input  logic             down,
  input  logic [7:0]       step,
  output pong_pkg::coord_t pos
);
  import pong_pkg::*;

  coord_t step_c;

  assign step_c = coord_t'(step);

  always_ff @(posedge clk) begin
    if (reset || init_game) begin
      pos <= coord_t'(active_lines / 2);    // mid screen
    end else if (motion_en) begin
      if (up) begin
        if (pos >= coord_t'(paddle_min) + step_c) begin
          pos <= pos - step_c;
        end else begin
          pos <= coord_t'(paddle_min);      // clamp at top
        end
      end else if (down) begin
        if (pos + step_c <= coord_t'(paddle_max)) begin
          pos <= pos + step_c;
        end else begin
          pos <= coord_t'(paddle_max);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ball_motion.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////////////////////////
// ball centre moves speed pixels on both axes once per frame
// a disabled paddle turns its side into a plain wall
//////////////////////////////////////////////////////////////////////

module ball_motion (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 frame_start,
  input  logic                 sec_tick,
  input  pong_pkg::play_ctrl_t ctrl,
  input  pong_pkg::coord_t     paddle_l_pos,
  input  pong_pkg::coord_t     paddle_r_pos,
  output pong_pkg::obj_t       ball_obj,
  output logic                 bounce,
  output logic                 game_failed
);
  import pong_pkg::*;

  coord_t                pos_x;
  coord_t                pos_y;
  coord_t                next_x;
  coord_t                next_y;
  logic                  dir_x;      // 1: towards the left paddle
  logic                  dir_y;      // 1: upwards
  logic                  wall_x;
  logic                  wall_y;
  logic                  hit;
  logic [speed_bits-1:0] speed;
  logic                  start_dir;  // start direction of the next game
  logic                  init_d;
  logic                  update;
  logic                  in_play;

  // one axis step, mirrored about the limit it crosses
  function automatic void axis_move(input coord_t pos, input logic neg, input coord_t step,
                                    input coord_t lo, input coord_t hi,
                                    output coord_t nxt, output logic wall);
    wall = 1'b0;
    nxt  = neg ? pos - step : pos + step;
    if (neg && pos < lo + step) begin
      nxt  = lo + lo + step - pos;
      wall = 1'b1;
    end else if (!neg && pos + step > hi) begin
      nxt  = hi + hi - pos - step;
      wall = 1'b1;
    end
  endfunction

  function automatic logic near(input coord_t a, input coord_t b);
    coord_t diff;
    diff = (a > b) ? a - b : b - a;
    return diff < coord_t'(paddle_hit_range);
  endfunction

  always_comb begin
    axis_move(pos_x, dir_x, coord_t'(speed), coord_t'(ball_min_x), coord_t'(ball_max_x),
              next_x, wall_x);
    axis_move(pos_y, dir_y, coord_t'(speed), coord_t'(ball_min_y), coord_t'(ball_max_y),
              next_y, wall_y);
    // west wall belongs to the left paddle, east wall to the right one
    if (dir_x) begin
      hit = !ctrl.paddle_l_en || near(pos_y, paddle_l_pos);
    end else begin
      hit = !ctrl.paddle_r_en || near(pos_y, paddle_r_pos);
    end
    update  = frame_start && ctrl.motion_en;
    in_play = ctrl.motion_en && (ctrl.paddle_l_en || ctrl.paddle_r_en);
  end

  // start direction flips on each new game
  always_ff @(posedge clk) begin
    if (reset) begin
      start_dir <= 1'b0;
      init_d    <= 1'b1;
    end else begin
      init_d <= ctrl.init_game;
      if (ctrl.init_game && !init_d) begin
        start_dir <= !start_dir;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // position, direction and speed
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || ctrl.init_game) begin
      pos_x       <= coord_t'(active_pels / 2);
      pos_y       <= coord_t'(active_lines / 2);
      dir_x       <= start_dir;
      dir_y       <= start_dir;
      speed       <= speed_bits'(start_speed);
      bounce      <= 1'b0;
      game_failed <= 1'b0;
    end else begin
      if (update) begin
        pos_x       <= next_x;
        pos_y       <= next_y;
        dir_x       <= dir_x ^ wall_x;
        dir_y       <= dir_y ^ wall_y;
        bounce      <= wall_y || (wall_x && hit);
        game_failed <= game_failed || (wall_x && !hit);   // held until next init
      end
      if (sec_tick && in_play) begin
        if (speed >= speed_bits'(max_speed - step_speed)) begin
          speed <= speed_bits'(max_speed);
        end else begin
          speed <= speed + speed_bits'(step_speed);
        end
      end
    end
  end

  // object corner trails the centre by one clock
  always_ff @(posedge clk) begin
    ball_obj.x <= pos_x - coord_t'(ball_size / 2);
    ball_obj.y <= pos_y - coord_t'(ball_size / 2);
    if (reset) begin
      ball_obj.en <= 1'b0;
    end else begin
      ball_obj.en <= ctrl.motion_en;
    end
  end

endmodule

`default_nettype wire

/* hdl/pong_top.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////////////////////////
// game core: mode machine, two paddles and the ball
// objects are top-left corners; the renderer picks text and colours from mode
//////////////////////////////////////////////////////////////////////

module pong_top #(
  parameter int clk_rate = 49500000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 frame_start,
  input  logic                 btn_l,
  input  logic                 btn_r,
  input  logic                 up_l,
  input  logic                 down_l,
  input  logic                 up_r,
  input  logic                 down_r,
  input  logic [7:0]           paddle_step,
  output pong_pkg::obj_t       ball_obj,
  output pong_pkg::obj_t       paddle_l_obj,
  output pong_pkg::obj_t       paddle_r_obj,
  output pong_pkg::game_mode_t mode,
  output logic                 play_sound
);
  import pong_pkg::*;

  play_ctrl_t ctrl;
  logic       sec_tick;
  logic       bounce;
  logic       game_failed;
  coord_t     paddle_l_pos;
  coord_t     paddle_r_pos;

  game_fsm #(
    .clk_rate (clk_rate)
  ) game_fsm_i (
    .clk,
    .reset,
    .btn_l,
    .btn_r,
    .game_failed,
    .bounce,
    .ctrl,
    .sec_tick,
    .mode,
    .play_sound
  );

  paddle_ctrl paddle_l_i (
    .clk,
    .reset,
    .init_game (ctrl.init_game),
    .motion_en (ctrl.motion_en),
    .up        (up_l),
    .down      (down_l),
    .step      (paddle_step),
    .pos       (paddle_l_pos)
  );

  paddle_ctrl paddle_r_i (
    .clk,
    .reset,
    .init_game (ctrl.init_game),
    .motion_en (ctrl.motion_en),
    .up        (up_r),
    .down      (down_r),
    .step      (paddle_step),
    .pos       (paddle_r_pos)
  );

  ball_motion ball_i (
    .clk,
    .reset,
    .frame_start,
    .sec_tick,
    .ctrl,
    .paddle_l_pos,
    .paddle_r_pos,
    .ball_obj,
    .bounce,
    .game_failed
  );

  //////////////////////////////////////////////////////////////////////
  // paddle objects, x sits on the ball's turning line
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    paddle_l_obj.x <= coord_t'(ball_min_x - ball_size / 2);
    paddle_r_obj.x <= coord_t'(ball_max_x - ball_size / 2);
    paddle_l_obj.y <= paddle_l_pos - coord_t'(paddle_size / 2);
    paddle_r_obj.y <= paddle_r_pos - coord_t'(paddle_size / 2);
    if (reset) begin
      paddle_l_obj.en <= 1'b0;
      paddle_r_obj.en <= 1'b0;
    end else begin
      paddle_l_obj.en <= ctrl.paddle_l_en;
      paddle_r_obj.en <= ctrl.paddle_r_en;
    end
  end

endmodule

`default_nettype wire

/* tests/pong_chk.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////////////////////////
// bound into pong_top
// object checks apply only while en is high
//////////////////////////////////////////////////////////////////////

module pong_chk (
  input logic           clk,
  input logic           reset,
  input pong_pkg::obj_t ball_obj,
  input pong_pkg::obj_t paddle_l_obj,
  input pong_pkg::obj_t paddle_r_obj,
  input logic           play_sound
);
  import pong_pkg::*;

  int failures = 0;   // failed assertions so far

  ball_in_field: assert property (@(posedge clk) disable iff (reset)
    ball_obj.en |-> ball_obj.x >= coord_t'(ball_min_x - ball_size / 2)
                 && ball_obj.x <= coord_t'(ball_max_x - ball_size / 2)
                 && ball_obj.y >= coord_t'(ball_min_y - ball_size / 2)
                 && ball_obj.y <= coord_t'(ball_max_y - ball_size / 2))
    else begin
      $error("ball object outside the playfield");
      failures = failures + 1;
    end

  // a centre below paddle_min wraps round and breaks the upper limit too
  paddle_l_range: assert property (@(posedge clk) disable iff (reset)
    paddle_l_obj.en |-> paddle_l_obj.y <= coord_t'(paddle_max - paddle_size / 2))
    else begin
      $error("left paddle outside its limits");
      failures = failures + 1;
    end

  paddle_r_range: assert property (@(posedge clk) disable iff (reset)
    paddle_r_obj.en |-> paddle_r_obj.y <= coord_t'(paddle_max - paddle_size / 2))
    else begin
      $error("right paddle outside its limits");
      failures = failures + 1;
    end

  // sound is a single clock pulse
  sound_pulse: assert property (@(posedge clk) disable iff (reset)
    play_sound |=> !play_sound)
    else begin
      $error("play_sound high on two cycles in a row");
      failures = failures + 1;
    end

endmodule

bind pong_top pong_chk chk_i (
  .clk,
  .reset,
  .ball_obj,
  .paddle_l_obj,
  .paddle_r_obj,
  .play_sound
);

`default_nettype wire

/* tests/pong_tb.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////////////////////////////////////////////
// directed tests of the game core at 16 clocks per second
// frame_start pulses every 8 clocks, inputs change on the falling edge
//////////////////////////////////////////////////////////////////////

module pong_tb;
  import pong_pkg::*;

  localparam int clk_rate    = 16;
  localparam int frame_len   = 8;
  localparam int miss_limit  = 4000;  // cycles for the one-player ball to get past
  localparam int test_cycles = 20 + (idle_timeout_sec + 2) * clk_rate + 200 * frame_len
                               + 300 + (wait_timeout_sec + 2) * clk_rate + miss_limit
                               + (finished_sec + 2) * clk_rate + 300 * frame_len;
  localparam int cycle_limit = test_cycles * 3 / 2;

  logic        clk = 1'b0;
  logic        reset;
  logic        frame_start = 1'b0;
  logic        btn_l;
  logic        btn_r;
  logic        up_l;
  logic        down_l;
  logic        up_r;
  logic        down_r;
  logic [7:0]  paddle_step;
  obj_t        ball_obj;
  obj_t        paddle_l_obj;
  obj_t        paddle_r_obj;
  game_mode_t  mode;
  logic        play_sound;
  logic [2:0]  frame_cnt = 3'd0;
  logic [31:0] lfsr = 32'h19f74cb9;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;

  pong_top #(
    .clk_rate (clk_rate)
  ) dut_i (
    .clk,
    .reset,
    .frame_start,
    .btn_l,
    .btn_r,
    .up_l,
    .down_l,
    .up_r,
    .down_r,
    .paddle_step,
    .ball_obj,
    .paddle_l_obj,
    .paddle_r_obj,
    .mode,
    .play_sound
  );

  initial begin
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    frame_cnt   <= frame_cnt + 3'd1;
    frame_start <= (frame_cnt == 3'd7);   // one pulse per 8 clocks
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // button held 1 to 4 clocks
  task automatic press(input logic right);
    int hold;
    draw_bits(2, hold);
    @(negedge clk);
    if (right) begin
      btn_r = 1'b1;
    end else begin
      btn_l = 1'b1;
    end
    repeat (hold + 1) @(negedge clk);
    btn_l = 1'b0;
    btn_r = 1'b0;
  endtask

  task automatic wait_mode(input game_mode_t target, input int limit);
    int n;
    n = 0;
    while (mode !== target && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (mode !== target) begin
      other_errors++;
      $display("mode %s was not reached within %0d cycles", target.name(), limit);
    end
  endtask

  // move a paddle centre towards the target line
  task automatic steer(input obj_t pad, input int target, output logic up, output logic down);
    int centre;
    int step;
    centre = int'(pad.y) + paddle_size / 2;
    step   = int'(paddle_step);
    up     = centre >= target + step;
    down   = centre + step <= target;
  endtask

  function automatic obj_t paddle_obj_at(input logic left, input int centre);
    obj_t o;
    o.x  = left ? coord_t'(ball_min_x - ball_size / 2) : coord_t'(ball_max_x - ball_size / 2);
    o.y  = coord_t'(centre - paddle_size / 2);
    o.en = 1'b1;
    return o;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_mode(input game_mode_t got, input game_mode_t exp, input string name);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_obj(input obj_t got, input obj_t exp, input string name);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got x=%0d y=%0d en=%b, expected x=%0d y=%0d en=%b",
               $time, name, got.x, got.y, got.en, exp.x, exp.y, exp.en);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic test_idle_demo();
    check_mode(mode, mode_idle, "mode");
    check_bit(play_sound, 1'b0, "play_sound");
    check_bit(ball_obj.en, 1'b0, "ball_obj.en");
    check_bit(paddle_l_obj.en, 1'b0, "paddle_l_obj.en");
    check_bit(paddle_r_obj.en, 1'b0, "paddle_r_obj.en");
    wait_mode(mode_demo, (idle_timeout_sec + 2) * clk_rate);
    run_cycles(2);                  // ctrl and object stages
    check_bit(ball_obj.en, 1'b1, "ball_obj.en");
    repeat (200 * frame_len) begin
      @(negedge clk);
      if (ball_obj.x < coord_t'(ball_min_x - ball_size / 2)
          || ball_obj.x > coord_t'(ball_max_x - ball_size / 2)
          || ball_obj.y < coord_t'(ball_min_y - ball_size / 2)
          || ball_obj.y > coord_t'(ball_max_y - ball_size / 2)) begin
        other_errors++;
        $display("ball left the playfield at %0t: x=%0d y=%0d", $time, ball_obj.x, ball_obj.y);
      end
    end
  endtask

  task automatic test_two_join();
    press(1'b1);
    check_mode(mode, mode_wait_left, "mode");
    press(1'b0);
    check_mode(mode, mode_two, "mode");
    run_cycles(2);
    check_obj(paddle_l_obj, paddle_obj_at(1'b1, active_lines / 2), "paddle_l_obj");
    check_obj(paddle_r_obj, paddle_obj_at(1'b0, active_lines / 2), "paddle_r_obj");
  endtask

  task automatic test_paddle_move();
    int step;
    int exp_y;
    draw_bits(4, step);
    step        = step + 8;         // 8 to 23 pixels per clock
    paddle_step = 8'(step);
    up_l        = 1'b1;
    run_cycles(20);
    up_l = 1'b0;
    run_cycles(1);                  // object trails position
    exp_y = active_lines / 2 - 20 * step;
    if (exp_y < paddle_min) begin
      exp_y = paddle_min;
    end
    check_obj(paddle_l_obj, paddle_obj_at(1'b1, exp_y), "paddle_l_obj");
    down_l = 1'b1;
    run_cycles((paddle_max - paddle_min) / step + 2);
    down_l = 1'b0;
    run_cycles(1);
    check_obj(paddle_l_obj, paddle_obj_at(1'b1, paddle_max), "paddle_l_obj");
  endtask

  task automatic test_one_player_miss();
    int sounds;
    int n;
    press(1'b0);
    check_mode(mode, mode_wait_right, "mode");
    wait_mode(mode_one_left, (wait_timeout_sec + 2) * clk_rate);
    up_l = 1'b1;                    // paddle pinned at the top
    wait_mode(mode_finished, miss_limit);
    sounds = 0;
    n      = 0;
    while (mode !== mode_idle && n < (finished_sec + 2) * clk_rate) begin
      if (play_sound) begin
        sounds++;
      end
      @(negedge clk);
      n++;
    end
    up_l = 1'b0;
    check_mode(mode, mode_idle, "mode");
    if (sounds != 1) begin
      other_errors++;
      $display("game over gave %0d play_sound pulses instead of one", sounds);
    end
  endtask

  task automatic test_bounce_sound();
    coord_t last_x;
    logic   have_dir;
    logic   dir;
    logic   new_dir;
    logic   sound_cur;
    logic   sound_prev;
    int     ball_y;
    int     flips;
    press(1'b0);
    press(1'b1);
    check_mode(mode, mode_two, "mode");
    paddle_step = 8'd4;
    last_x      = ball_obj.x;
    have_dir    = 1'b0;
    dir         = 1'b0;
    sound_cur   = 1'b0;
    sound_prev  = 1'b0;
    flips       = 0;
    repeat (300 * frame_len) begin
      @(negedge clk);
      ball_y = int'(ball_obj.y) + ball_size / 2;
      steer(paddle_l_obj, ball_y, up_l, down_l);
      steer(paddle_r_obj, ball_y, up_r, down_r);
      sound_cur = sound_cur | play_sound;
      if (ball_obj.x != last_x) begin
        new_dir = ball_obj.x < last_x;
        // a mirror step can hide the turn for one frame
        if (have_dir && new_dir != dir) begin
          flips++;
          check_bit(sound_cur | sound_prev, 1'b1, "play_sound");
        end
        have_dir   = 1'b1;
        dir        = new_dir;
        last_x     = ball_obj.x;
        sound_prev = sound_cur;
        sound_cur  = 1'b0;
      end
    end
    up_l   = 1'b0;
    down_l = 1'b0;
    up_r   = 1'b0;
    down_r = 1'b0;
    check_mode(mode, mode_two, "mode");
    if (flips == 0) begin
      other_errors++;
      $display("no paddle bounce was seen in two-player mode");
    end
  endtask

  initial begin
    int asserts;
    reset       = 1'b1;
    btn_l       = 1'b0;
    btn_r       = 1'b0;
    up_l        = 1'b0;
    down_l      = 1'b0;
    up_r        = 1'b0;
    down_r      = 1'b0;
    paddle_step = 8'd0;
    apply_reset();
    test_idle_demo();
    test_two_join();
    test_paddle_move();
    apply_reset();
    test_one_player_miss();
    test_bounce_sound();
    asserts = dut_i.chk_i.failures;
    $display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors, asserts);
    if (value_errors + other_errors + asserts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/pong_pkg.sv
hdl/game_fsm.sv
hdl/paddle_ctrl.sv
hdl/ball_motion.sv
hdl/pong_top.sv
tests/pong_chk.sv
tests/pong_tb.sv

/* Makefile */
# Verilator build and run of the game core testbench
VERILATOR ?= verilator
TOP       ?= pong_tb
FILE_LIST ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	  [ $$status -eq 0 ] && echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
